//--- common/alu_pkg.sv
// shared types for the 8-bit alu with 16-bit register-pair operations
// only the carry and zero flags exist, all other cpu flags live elsewhere
// the code field of an op is raw, each unit reads it in its own class enum
// byte-wide results keep a's hi byte in the result word

package alu_pkg;

	localparam int byte_width = 8;
	localparam int pair_width = 16;

	typedef logic [byte_width-1:0] byte_t;

	typedef struct packed
	{
		byte_t hi;
		byte_t lo;
	} pair_bytes_t;

	// one register pair, read as a word or as two bytes
	typedef union packed
	{
		logic [pair_width-1:0] word;
		pair_bytes_t part;
	} pair_u;

	typedef enum logic [1:0]
	{
		cls_arith = 2'd0,
		cls_logic = 2'd1,
		cls_shift = 2'd2,
		cls_reserved = 2'd3
	} op_class_e;

	typedef enum logic [3:0]
	{
		ar_add = 4'h0,
		ar_adc = 4'h1,
		ar_addpb = 4'h2,
		ar_addp = 4'h3,
		ar_addpsnx = 4'h4,
		ar_sub = 4'h5,
		ar_sbc = 4'h6,
		ar_subpb = 4'h7,
		ar_subp = 4'h8
	} arith_code_e;

	typedef enum logic [3:0]
	{
		lg_and = 4'h0,
		lg_orr = 4'h1,
		lg_xor = 4'h2,
		lg_inv = 4'h3,
		lg_invp = 4'h4,
		lg_neg = 4'h5,
		lg_negp = 4'h6
	} logic_code_e;

	typedef enum logic [3:0]
	{
		sh_lsl = 4'h0,
		sh_lsr = 4'h1,
		sh_asr = 4'h2,
		sh_rol = 4'h3,
		sh_ror = 4'h4,
		sh_rolc = 4'h5,
		sh_rorc = 4'h6
	} shift_code_e;

	typedef struct packed
	{
		op_class_e op_class;
		logic [3:0] code;
	} alu_op_t;

	typedef struct packed
	{
		logic z;
		logic c;
	} flags_t;

	typedef struct packed
	{
		alu_op_t op;
		pair_u a;
		pair_u b;
		flags_t flags;
	} alu_req_t;

	typedef struct packed
	{
		pair_u result;
		flags_t flags;
	} alu_res_t;

	// wide marks a 16-bit result, keep_z leaves the zero flag alone
	typedef struct packed
	{
		pair_u result;
		logic carry;
		logic wide;
		logic keep_z;
	} unit_res_t;

endpackage

//--- alu/addsub_unit.sv
// add and subtract unit, byte and register-pair forms, purely combinational
// subtraction adds the inverted operand, so carry out means no borrow
// addpb and subpb zero-extend b's lo byte, addpsnx sign-extends it
// unknown codes return a with carry and zero untouched

`timescale 1ns/10ps

module addsub_unit
(
	input alu_pkg::alu_req_t req,
	output alu_pkg::unit_res_t res
);
	import alu_pkg::*;

	logic [pair_width-1:0] b_ext;
	logic [pair_width-1:0] b_word;
	logic sub;
	logic cin;
	logic wide;
	logic known;
	logic [pair_width:0] sum_pair;
	logic [byte_width:0] sum_byte;

	// operand shaping per code
	always_comb
	begin
		b_ext = {{byte_width{1'b0}}, req.b.part.lo};
		sub = 1'b0;
		cin = 1'b0;
		wide = 1'b0;
		known = 1'b1;
		case (arith_code_e'(req.op.code))
			ar_add: ;
			ar_adc: cin = req.flags.c;
			ar_addpb: wide = 1'b1;
			ar_addp:
			begin
				b_ext = req.b.word;
				wide = 1'b1;
			end
			ar_addpsnx:
			begin
				b_ext = {{byte_width{req.b.part.lo[byte_width-1]}}, req.b.part.lo};
				wide = 1'b1;
			end
			ar_sub:
			begin
				sub = 1'b1;
				cin = 1'b1;
			end
			ar_sbc:
			begin
				sub = 1'b1;
				cin = req.flags.c;
			end
			ar_subpb:
			begin
				sub = 1'b1;
				cin = 1'b1;
				wide = 1'b1;
			end
			ar_subp:
			begin
				b_ext = req.b.word;
				sub = 1'b1;
				cin = 1'b1;
				wide = 1'b1;
			end
			default: known = 1'b0;
		endcase
	end

	assign b_word = sub ? ~b_ext : b_ext;

	// both adders run, the width picks one
	assign sum_pair = {1'b0, req.a.word} + {1'b0, b_word} + {{pair_width{1'b0}}, cin};
	assign sum_byte = {1'b0, req.a.part.lo} + {1'b0, b_word[byte_width-1:0]}
		+ {{byte_width{1'b0}}, cin};

	always_comb
	begin
		res.result = req.a;
		res.carry = req.flags.c;
		res.wide = 1'b0;
		res.keep_z = 1'b1;
		if (known)
		begin
			res.keep_z = 1'b0;
			res.wide = wide;
			if (wide)
			begin
				{res.carry, res.result.word} = sum_pair;
			end
			else
			begin
				{res.carry, res.result.part.lo} = sum_byte;
			end
		end
	end

endmodule

//--- alu/logic_unit.sv
// bitwise, complement and negate operations
// byte forms work on the lo bytes and keep a's hi byte
// invp and negp work on the whole pair
// carry always passes through

`timescale 1ns/10ps

module logic_unit
(
	input alu_pkg::alu_req_t req,
	output alu_pkg::unit_res_t res
);
	import alu_pkg::*;

	always_comb
	begin
		res.result = req.a;
		res.carry = req.flags.c;
		res.wide = 1'b0;
		res.keep_z = 1'b0;
		case (logic_code_e'(req.op.code))
			lg_and: res.result.part.lo = req.a.part.lo & req.b.part.lo;
			lg_orr: res.result.part.lo = req.a.part.lo | req.b.part.lo;
			lg_xor: res.result.part.lo = req.a.part.lo ^ req.b.part.lo;
			lg_inv: res.result.part.lo = ~req.a.part.lo;
			lg_invp:
			begin
				res.result.word = ~req.a.word;
				res.wide = 1'b1;
			end
			// two's complement negate
			lg_neg: res.result.part.lo = -req.a.part.lo;
			lg_negp:
			begin
				res.result.word = -req.a.word;
				res.wide = 1'b1;
			end
			// unknown code, a passes with z untouched
			default: res.keep_z = 1'b1;
		endcase
	end

endmodule

//--- alu/shift_rotate_unit.sv
// 8-bit shifts and rotates on a's lo byte, count taken from b's lo byte
// shifts run in a 9-bit frame with carry, counts above 8 give carry 0
// rol and ror use the count modulo 8 and keep carry
// a zero count returns a with carry and zero untouched
// rolc and rorc always move one bit through carry

`timescale 1ns/10ps

module shift_rotate_unit
(
	input alu_pkg::alu_req_t req,
	output alu_pkg::unit_res_t res
);
	import alu_pkg::*;

	byte_t count;
	byte_t rot_amt;
	logic [byte_width:0] frame;
	logic [2*byte_width-1:0] rot;
	logic counted;

	assign count = req.b.part.lo;
	assign rot_amt = byte_t'(count % byte_width);

	always_comb
	begin
		frame = '0;
		rot = '0;
		counted = 1'b1;
		res.result = req.a;
		res.carry = req.flags.c;
		res.wide = 1'b0;
		res.keep_z = 1'b0;
		case (shift_code_e'(req.op.code))
			sh_lsl:
			begin
				frame = {1'b0, req.a.part.lo} << count;
				{res.carry, res.result.part.lo} = frame;
			end
			sh_lsr:
			begin
				frame = {req.a.part.lo, 1'b0} >> count;
				{res.result.part.lo, res.carry} = frame;
			end
			sh_asr:
			begin
				frame = $signed({req.a.part.lo, 1'b0}) >>> count;
				res.result.part.lo = frame[byte_width:1];
				// past 8 the carry reads 0, not the sign
				res.carry = (count > byte_t'(byte_width)) ? 1'b0 : frame[0];
			end
			sh_rol:
			begin
				rot = {req.a.part.lo, req.a.part.lo} << rot_amt;
				res.result.part.lo = rot[2*byte_width-1:byte_width];
			end
			sh_ror:
			begin
				rot = {req.a.part.lo, req.a.part.lo} >> rot_amt;
				res.result.part.lo = rot[byte_width-1:0];
			end
			sh_rolc:
			begin
				counted = 1'b0;
				{res.carry, res.result.part.lo} = {req.a.part.lo, req.flags.c};
			end
			sh_rorc:
			begin
				counted = 1'b0;
				{res.result.part.lo, res.carry} = {req.flags.c, req.a.part.lo};
			end
			default:
			begin
				counted = 1'b0;
				res.keep_z = 1'b1;
			end
		endcase

		// zero count changes nothing at all
		if (counted && count == '0)
		begin
			res.result = req.a;
			res.carry = req.flags.c;
			res.keep_z = 1'b1;
		end
	end

endmodule

//--- alu/alu_core.sv
// alu core, picks one unit by op class and forms the flags
// the reserved class passes a through with both flags unchanged
// z is tested on the lo byte or on the word, by the unit's width
// combinational, no latency

`timescale 1ns/10ps

module alu_core
(
	input alu_pkg::alu_req_t req,
	output alu_pkg::alu_res_t res
);
	import alu_pkg::*;

	unit_res_t arith_res;
	unit_res_t logic_res;
	unit_res_t shift_res;
	unit_res_t sel;

	addsub_unit i_addsub
	(
		.req(req),
		.res(arith_res)
	);

	logic_unit i_logic
	(
		.req(req),
		.res(logic_res)
	);

	shift_rotate_unit i_shift
	(
		.req(req),
		.res(shift_res)
	);

	// class select
	always_comb
	begin
		case (req.op.op_class)
			cls_arith: sel = arith_res;
			cls_logic: sel = logic_res;
			cls_shift: sel = shift_res;
			default:
			begin
				sel.result = req.a;
				sel.carry = req.flags.c;
				sel.wide = 1'b0;
				sel.keep_z = 1'b1;
			end
		endcase
	end

	assign res.result = sel.result;
	assign res.flags.c = sel.carry;

	// zero flag
	always_comb
	begin
		if (sel.keep_z)
		begin
			res.flags.z = req.flags.z;
		end
		else if (sel.wide)
		begin
			res.flags.z = (sel.result.word == '0);
		end
		else
		begin
			res.flags.z = (sel.result.part.lo == '0);
		end
	end

endmodule

//--- verilog/alu_stage.sv
// alu top level with one register stage on the result
// a request taken with in_valid shows on res one clk later with out_valid
// out_valid is a one-cycle pulse, res holds until the next request
// no back-pressure, one request may enter every cycle

`timescale 1ns/10ps

module alu_stage
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input alu_pkg::alu_req_t req,
	output logic out_valid,
	output alu_pkg::alu_res_t res
);
	import alu_pkg::*;

	alu_res_t core_res;

	alu_core i_core
	(
		.req(req),
		.res(core_res)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			res <= '0;
		end
		else
		begin
			out_valid <= in_valid;
			// only a valid request updates the result
			if (in_valid)
			begin
				res <= core_res;
			end
		end
	end

endmodule

//--- tb/tb_clock_gen.sv
// clock and reset for the alu testbench
// 40 ns clock period
// rst is high over the first two rising edges and drops on a falling edge

`timescale 1ns/10ps

module tb_clock_gen
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#20 clk = ~clk;
		end
	end

	initial
	begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- tb/tb_alu_stage.sv
// testbench for alu_stage, requests and expected results come from tb/alu_trace.txt
// must be run from the project root so that the trace path resolves
// inputs change on the falling edge, outputs are sampled there as well
// requests go in bursts of four back to back, then one idle cycle
// stops at the first mismatch

`timescale 1ns/10ps

module tb_alu_stage;
	import alu_pkg::*;

	localparam int wait_limit = 20;
	localparam int burst_len = 4;

	logic clk;
	logic rst;
	logic in_valid;
	alu_req_t req;
	logic out_valid;
	alu_res_t res;

	alu_req_t req_q[$];
	alu_res_t exp_q[$];

	tb_clock_gen i_clock
	(
		.clk(clk),
		.rst(rst)
	);

	alu_stage i_dut
	(
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.req(req),
		.out_valid(out_valid),
		.res(res)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_result(input pair_u got, input pair_u exp, input int entry);
		if (got !== exp)
		begin
			stop_run($sformatf("Fail: res.result = %h, expected %h, trace entry %0d",
				got.word, exp.word, entry));
		end
	endtask

	// flags print as {z,c}
	task automatic check_flags(input flags_t got, input flags_t exp, input int entry);
		if (got !== exp)
		begin
			stop_run($sformatf("Fail: res.flags = %h, expected %h, trace entry %0d",
				got, exp, entry));
		end
	endtask

	task automatic check_valid(input logic got, input logic exp, input string when);
		if (got !== exp)
		begin
			stop_run($sformatf("Fail: out_valid = %h, expected %h, %s", got, exp, when));
		end
	endtask

	task automatic load_trace();
		int fd;
		int n;
		string line;
		logic [1:0] cls;
		logic [3:0] code;
		logic [1:0] fl_in;
		logic [15:0] a_in;
		logic [15:0] b_in;
		logic [15:0] res_exp;
		logic [1:0] fl_exp;
		alu_req_t r;
		alu_res_t e;
		fd = $fopen("tb/alu_trace.txt", "r");
		if (fd == 0)
		begin
			stop_run("the trace file tb/alu_trace.txt could not be opened");
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line[0] == "#")
			begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h",
				cls, code, fl_in, a_in, b_in, res_exp, fl_exp);
			// blank lines give no fields
			if (n > 0 && n != 7)
			begin
				stop_run({"a line of the trace file has the wrong number of fields: ", line});
			end
			if (n == 7)
			begin
				r.op.op_class = op_class_e'(cls);
				r.op.code = code;
				r.a.word = a_in;
				r.b.word = b_in;
				r.flags = fl_in;
				e.result.word = res_exp;
				e.flags = fl_exp;
				req_q.push_back(r);
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
		if (req_q.size() == 0)
		begin
			stop_run("the trace file holds no requests");
		end
	endtask

	task automatic wait_reset();
		int cycles;
		cycles = 0;
		while (rst !== 1'b0)
		begin
			if (cycles == wait_limit)
			begin
				stop_run("timeout while waiting for reset to be released");
			end
			@(posedge clk);
			cycles++;
		end
		@(negedge clk);
	endtask

	// returns at the falling edge where out_valid is seen
	task automatic wait_result();
		int cycles;
		cycles = 0;
		while (cycles < wait_limit)
		begin
			@(negedge clk);
			cycles++;
			if (out_valid === 1'b1)
			begin
				break;
			end
			// no second copy of the request
			in_valid = 1'b0;
		end
		if (out_valid !== 1'b1)
		begin
			stop_run("timeout while waiting for out_valid");
		end
		if (cycles != 1)
		begin
			stop_run($sformatf("Fail: out_valid latency = %h cycles, expected %h",
				cycles, 1));
		end
	endtask

	initial
	begin
		// a request offered during reset must not get through
		in_valid = 1'b1;
		req = '1;
		load_trace();
		@(negedge clk);
		check_valid(out_valid, 1'b0, "during reset");
		check_result(res.result, '0, -1);
		check_flags(res.flags, '0, -1);
		in_valid = 1'b0;
		req = '0;
		wait_reset();
		check_valid(out_valid, 1'b0, "after reset");
		check_result(res.result, '0, -1);
		check_flags(res.flags, '0, -1);

		for (int i = 0; i < req_q.size(); i++)
		begin
			in_valid = 1'b1;
			req = req_q[i];
			wait_result();
			check_result(res.result, exp_q[i].result, i);
			check_flags(res.flags, exp_q[i].flags, i);
			if (i % burst_len == burst_len - 1)
			begin
				// idle cycle, junk on req must not reach res
				in_valid = 1'b0;
				req = '1;
				@(negedge clk);
				check_valid(out_valid, 1'b0, $sformatf("idle cycle after trace entry %0d", i));
				check_result(res.result, exp_q[i].result, i);
				check_flags(res.flags, exp_q[i].flags, i);
			end
		end

		in_valid = 1'b0;
		@(negedge clk);
		check_valid(out_valid, 1'b0, "after the last request");
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- tb/alu_trace.txt
# class code flags_in a b result flags_out, all hex
# flags are {z,c}; class 0 arith, 1 logic, 2 shift, 3 reserved
0 0 0 1234 00f0 1224 1
0 0 0 5580 0080 5500 3
0 1 1 0010 0020 0031 0
0 1 2 00ff 0001 0000 3
0 5 0 0050 0030 0020 1
0 5 0 7730 0050 77e0 0
0 5 0 0042 0042 0000 3
0 6 1 0050 0030 0020 1
0 6 0 0050 0030 001f 1
0 6 0 0000 0000 00ff 0
0 2 0 12f0 aa20 1310 0
0 3 0 80ff 8001 0100 1
0 3 0 ffff 0001 0000 3
0 4 0 1200 00ff 11ff 1
0 4 0 12f0 ff10 1300 0
0 7 0 1300 0001 12ff 1
0 8 0 0100 0200 ff00 0
0 8 0 1234 1234 0000 3
0 9 2 5678 1111 5678 2
1 0 1 ab3c 550f ab0c 1
1 0 0 12f0 000f 1200 2
1 1 1 4010 0003 4013 1
1 2 0 77aa 00aa 7700 2
1 3 1 0f0f 0000 0ff0 1
1 4 0 ffff 0000 0000 2
1 4 1 00ff 0000 ff00 1
1 5 0 3401 0000 34ff 0
1 6 1 0001 0000 ffff 1
1 6 0 0000 0000 0000 2
2 0 0 1281 0001 1202 1
2 0 0 0021 0003 0008 1
2 0 1 00ff 0009 0000 2
2 1 0 0081 0001 0040 1
2 1 0 0080 0008 0000 3
2 2 0 0084 0002 00e1 0
2 2 0 0004 0003 0000 3
2 2 1 0080 000a 00ff 0
2 3 1 5081 000b 500c 1
2 4 0 0081 000b 0030 0
2 5 0 0080 0000 0000 3
2 6 0 0001 0001 0000 3
2 6 1 0002 0000 0081 0
2 0 1 1200 0000 1200 1
2 1 2 00ff 0000 00ff 2
2 2 3 0080 1200 0080 3
2 3 0 3400 0000 3400 0
2 4 2 abcd 0000 abcd 2
3 0 1 0000 1234 0000 1
3 5 2 beef 0000 beef 2

//--- flist.f
common/alu_pkg.sv
alu/addsub_unit.sv
alu/logic_unit.sv
alu/shift_rotate_unit.sv
alu/alu_core.sv
verilog/alu_stage.sv
tb/tb_clock_gen.sv
tb/tb_alu_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the alu testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module tb_alu_stage -f flist.f \
	--Mdir obj_dir -o tb_alu_stage_sim > build.log 2>&1 \
	&& ./obj_dir/tb_alu_stage_sim > sim.log 2>&1
grep -q "SOME TESTS FAILED" sim.log 2>/dev/null && { echo "FAIL: see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null && echo "PASS" \
	|| { echo "FAIL: see build.log and sim.log"; exit 1; }
